// ==== Bender.yml ====
package:
  name: mips_exec

sources:
  - files:
      - verilog/mips_isa_pkg.sv
      - verilog/mips_alu_pkg.sv
      - verilog/mips_decoder.sv
      - verilog/mips_regfile.sv
      - verilog/mips_alu.sv
      - verilog/mips_exec_unit.sv
  - target: test
    files:
      - bench/mips_exec_tb.sv

// ==== bench/mips_exec_tb.sv ====
// testbench with clock, reset, random stimulus, shadow register model and result checks
`timescale 1ns/100ps
`default_nettype none

module mips_exec_tb
    import mips_isa_pkg::*;
    import mips_alu_pkg::*;
();

    typedef struct packed {
        logic [31:0] value;
        logic        zero;
        logic        neg;
        reg_addr_t   dest;
        logic        illegal;
    } expect_t;

    logic      clk_i;
    logic      rst_n_i;
    logic      instr_valid_i;
    instr_t    instr_i;
    logic      result_valid_o;
    alu_res_t  result_o;
    reg_addr_t dest_o;
    logic      illegal_o;

    logic [31:0] shadow [0:REG_COUNT-1];
    expect_t     exp_q [$];
    expect_t     cur_exp;
    int          err_value;
    int          err_flag;
    int          err_ctrl;
    int          err_other;
    int          issued;
    int          retired;

    mips_exec_unit dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .dest_o         (dest_o),
        .illegal_o      (illegal_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic expect_t predict(input instr_t w);
        expect_t     e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        a    = shadow[w.r.rs];
        b    = shadow[w.r.rt];
        sext = {{16{w.i.imm[15]}}, w.i.imm};
        zext = {16'h0000, w.i.imm};
        e    = '0;
        e.dest = w.i.rt;
        case (w.r.opcode)
            OP_RTYPE: begin
                e.dest = w.r.rd;
                case (w.r.funct)
                    FN_ADD:  e.value = a + b;
                    FN_SUB:  e.value = a - b;
                    FN_AND:  e.value = a & b;
                    FN_OR:   e.value = a | b;
                    FN_XOR:  e.value = a ^ b;
                    FN_NOR:  e.value = ~(a | b);
                    FN_SLT:  e.value = {31'd0, $signed(a) < $signed(b)};
                    FN_SLTU: e.value = {31'd0, a < b};
                    FN_SLL:  e.value = b << w.r.shamt;
                    FN_SRL:  e.value = b >> w.r.shamt;
                    FN_SRA:  e.value = $signed(b) >>> w.r.shamt;   // sign fill.
                    default: e.illegal = 1'b1;
                endcase
            end
            OP_ADDI:  e.value = a + sext;
            OP_SLTI:  e.value = {31'd0, $signed(a) < $signed(sext)};
            OP_SLTIU: e.value = {31'd0, a < sext};
            OP_ANDI:  e.value = a & zext;
            OP_ORI:   e.value = a | zext;
            OP_XORI:  e.value = a ^ zext;
            OP_LUI:   e.value = {w.i.imm, 16'h0000};
            default:  e.illegal = 1'b1;
        endcase
        if (e.illegal) begin
            e.value = '0;
            e.dest  = '0;
        end
        e.zero = (e.value == 32'd0);
        e.neg  = e.value[31];
        return e;
    endfunction

    function automatic instr_t rtype_word(input logic [5:0] fn, input reg_addr_t rs,
                                          input reg_addr_t rt, input reg_addr_t rd,
                                          input logic [4:0] sh);
        instr_t w;
        w.r = '{opcode: OP_RTYPE, rs: rs, rt: rt, rd: rd, shamt: sh, funct: fn};
        return w;
    endfunction

    function automatic instr_t itype_word(input logic [5:0] op, input reg_addr_t rs,
                                          input reg_addr_t rt, input logic [15:0] imm);
        instr_t w;
        w.i = '{opcode: op, rs: rs, rt: rt, imm: imm};
        return w;
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'($urandom_range(REG_COUNT - 1, 0));
    endfunction

    function automatic logic [15:0] rand_imm();
        return 16'($urandom);
    endfunction

    function automatic logic known_opcode(input logic [5:0] op);
        return op inside {OP_RTYPE, OP_ADDI, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    endfunction

    function automatic logic known_funct(input logic [5:0] fn);
        return fn inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOR,
                          FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
    endfunction

    task automatic issue(input instr_t w);
        expect_t e;
        @(posedge clk_i);
        instr_valid_i <= 1'b1;
        instr_i       <= w;
        e = predict(w);
        exp_q.push_back(e);
        if (!e.illegal && e.dest != '0) begin
            shadow[e.dest] = e.value;
        end
        issued++;
    endtask

    task automatic drain();
        int cycles;
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 16) begin
            @(posedge clk_i);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d results still missing after 16 idle cycles", exp_q.size());
            $display("Test failures found");
            $finish;
        end
    endtask

    task automatic load_registers();
        for (int r = 1; r < REG_COUNT; r++) begin
            issue(itype_word(OP_LUI, '0, reg_addr_t'(r), rand_imm()));
            issue(itype_word(OP_ORI, reg_addr_t'(r), reg_addr_t'(r), rand_imm()));
        end
        drain();
    endtask

    // results are paired with their expectation between clock edges.
    always @(negedge clk_i) begin
        if (rst_n_i && result_valid_o) begin
            if (exp_q.size() == 0) begin
                err_other++;
                $display("result valid at %0t with no instruction outstanding", $time);
            end else begin
                cur_exp = exp_q.pop_front();
                retired++;
            end
        end
    end

    // one result pulse per issue, one cycle later.
    a_latency : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_valid_o == $past(instr_valid_i))
    else begin
        err_other++;
        $display("** Error [%0t] result valid %b does not follow the issue strobe by one cycle",
                 $time, $sampled(result_valid_o));
    end

    a_value : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_valid_o |-> (result_o.value == cur_exp.value))
    else begin
        err_value++;
        $display("** Error [%0t] result value %h, expected %h", $time,
                 $sampled(result_o.value), cur_exp.value);
    end

    a_flags : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_valid_o |-> (result_o.zero == cur_exp.zero && result_o.neg == cur_exp.neg))
    else begin
        err_flag++;
        $display("** Error [%0t] flags z=%b n=%b, expected z=%b n=%b", $time,
                 $sampled(result_o.zero), $sampled(result_o.neg), cur_exp.zero, cur_exp.neg);
    end

    a_dest_illegal : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_valid_o |-> (dest_o == cur_exp.dest && illegal_o == cur_exp.illegal))
    else begin
        err_ctrl++;
        $display("** Error [%0t] dest %0d illegal %b, expected dest %0d illegal %b", $time,
                 $sampled(dest_o), $sampled(illegal_o), cur_exp.dest, cur_exp.illegal);
    end

    initial begin
        reg_addr_t  ra;
        logic [5:0] code;
        int         total;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        cur_exp       = '0;
        for (int r = 0; r < REG_COUNT; r++) begin
            shadow[r] = '0;
        end
        void'($urandom(32'hcd8f));

        repeat (4) @(posedge clk_i);
        a_reset_state : assert (!result_valid_o && !illegal_o && result_o == '0 && dest_o == '0)
        else begin
            err_other++;
            $display("** Error [%0t] outputs not cleared during reset", $time);
        end
        rst_n_i <= 1'b1;

        // every register pair reads zero before any write.
        for (int s = 0; s < REG_COUNT; s++) begin
            for (int t = 0; t < REG_COUNT; t++) begin
                issue(rtype_word(FN_ADD, reg_addr_t'(s), reg_addr_t'(t), '0, 5'd0));
            end
        end
        drain();

        load_registers();
        for (int k = 0; k < 200; k++) begin
            case ($urandom_range(5, 0))
                0: code = FN_ADD;
                1: code = FN_SUB;
                2: code = FN_AND;
                3: code = FN_OR;
                4: code = FN_XOR;
                default: code = FN_NOR;
            endcase
            issue(rtype_word(code, rand_reg(), rand_reg(), rand_reg(), 5'd0));
        end
        drain();

        load_registers();
        foreach (shadow[k]) begin
            code = (k % 3 == 0) ? FN_SLL : (k % 3 == 1) ? FN_SRL : FN_SRA;
            issue(rtype_word(code, '0, rand_reg(), rand_reg(), 5'd0));
            issue(rtype_word(code, '0, rand_reg(), rand_reg(), 5'd31));
            issue(rtype_word(code, '0, rand_reg(), rand_reg(), 5'($urandom)));
        end
        drain();

        load_registers();
        for (int k = 0; k < 150; k++) begin
            case ($urandom_range(6, 0))
                0: code = OP_ADDI;
                1: code = OP_SLTI;
                2: code = OP_SLTIU;
                3: code = OP_ANDI;
                4: code = OP_ORI;
                5: code = OP_XORI;
                default: code = OP_LUI;
            endcase
            issue(itype_word(code, rand_reg(), rand_reg(), rand_imm()));
        end
        drain();

        // equal and sign-differing compare operands.
        issue(rtype_word(FN_OR, 5'd2, 5'd0, 5'd1, 5'd0));
        issue(rtype_word(FN_SLT, 5'd1, 5'd2, 5'd3, 5'd0));
        issue(rtype_word(FN_SLTU, 5'd1, 5'd2, 5'd3, 5'd0));
        issue(itype_word(OP_LUI, '0, 5'd4, 16'h8000));
        issue(itype_word(OP_ADDI, '0, 5'd5, 16'h0001));
        issue(rtype_word(FN_SLT, 5'd4, 5'd5, 5'd6, 5'd0));
        issue(rtype_word(FN_SLTU, 5'd4, 5'd5, 5'd6, 5'd0));
        issue(rtype_word(FN_SLT, 5'd5, 5'd4, 5'd6, 5'd0));
        issue(rtype_word(FN_SLTU, 5'd5, 5'd4, 5'd6, 5'd0));
        issue(itype_word(OP_SLTI, 5'd4, 5'd6, 16'h0001));
        issue(itype_word(OP_SLTIU, 5'd5, 5'd6, 16'hffff));
        issue(itype_word(OP_ADDI, '0, 5'd7, 16'hfffb));
        issue(itype_word(OP_SLTI, 5'd7, 5'd8, 16'hfffb));
        issue(itype_word(OP_SLTIU, 5'd7, 5'd8, 16'hfffb));
        for (int k = 0; k < 100; k++) begin
            code = $urandom_range(1, 0) ? FN_SLT : FN_SLTU;
            issue(rtype_word(code, rand_reg(), rand_reg(), rand_reg(), 5'd0));
            code = $urandom_range(1, 0) ? OP_SLTI : OP_SLTIU;
            issue(itype_word(code, rand_reg(), rand_reg(), rand_imm()));
        end
        drain();

        // register zero, illegal encodings and back-to-back dependencies.
        issue(itype_word(OP_ADDI, 5'd5, '0, 16'h007b));
        issue(rtype_word(FN_NOR, 5'd0, 5'd0, 5'd0, 5'd0));
        issue(rtype_word(FN_ADD, 5'd0, 5'd0, 5'd9, 5'd0));
        issue(itype_word(OP_ADDI, '0, 5'd10, 16'h0055));
        issue(itype_word(6'b100011, 5'd1, 5'd10, rand_imm()));
        issue(rtype_word(6'b011000, 5'd1, 5'd2, 5'd10, 5'd0));
        issue(rtype_word(FN_ADD, 5'd10, 5'd0, 5'd11, 5'd0));
        for (int k = 0; k < 40; k++) begin
            ra = rand_reg();
            do code = 6'($urandom); while (known_opcode(code));
            issue(itype_word(code, rand_reg(), ra, rand_imm()));
            do code = 6'($urandom); while (known_funct(code));
            issue(rtype_word(code, rand_reg(), rand_reg(), ra, 5'($urandom)));
            issue(rtype_word(FN_OR, ra, 5'd0, rand_reg(), 5'd0));
        end
        issue(itype_word(OP_ADDI, '0, 5'd12, 16'h0007));
        issue(rtype_word(FN_ADD, 5'd12, 5'd12, 5'd12, 5'd0));
        issue(rtype_word(FN_ADD, 5'd12, 5'd12, 5'd12, 5'd0));
        issue(rtype_word(FN_SLL, 5'd0, 5'd12, 5'd13, 5'd3));
        issue(rtype_word(FN_SUB, 5'd12, 5'd13, 5'd13, 5'd0));
        drain();
        repeat (2) @(posedge clk_i);

        if (issued != retired) begin
            err_other++;
            $display("%0d instructions issued but %0d results seen", issued, retired);
        end
        total = err_value + err_flag + err_ctrl + err_other;
        $display("errors: value %0d, flags %0d, dest/illegal %0d, other %0d (%0d instructions)",
                 err_value, err_flag, err_ctrl, err_other, issued);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/mips_isa_pkg.sv
verilog/mips_alu_pkg.sv
verilog/mips_decoder.sv
verilog/mips_regfile.sv
verilog/mips_alu.sv
verilog/mips_exec_unit.sv
bench/mips_exec_tb.sv

// ==== verilog/mips_alu.sv ====
// ALU with adder, shifter, logic unit, comparators, result select and flags
`timescale 1ns/100ps
`default_nettype none

module mips_alu
    import mips_alu_pkg::*;
(
    input  wire [31:0]  opr_a_i,
    input  wire [31:0]  opr_b_i,
    input  wire [4:0]   shamt_i,
    input  wire [5:0]   op_i,
    output alu_res_t    res_o
);

    logic        cin;
    logic [31:0] opr_b_eff;
    logic [32:0] sum_ext;
    logic [31:0] sum;
    logic        carry_out;
    logic        ovf;
    logic        lt_signed;
    logic        lt_unsigned;
    logic [31:0] shift_res;
    logic [31:0] logic_res;
    logic [31:0] value;

    // one adder for add, sub and both compares
    assign cin       = op_i[0];
    assign opr_b_eff = cin ? ~opr_b_i : opr_b_i;
    assign sum_ext   = {1'b0, opr_a_i} + {1'b0, opr_b_eff} + {32'd0, cin};
    assign sum       = sum_ext[31:0];
    assign carry_out = sum_ext[32];

    assign ovf         = (opr_a_i[31] == opr_b_eff[31]) && (sum[31] != opr_a_i[31]);
    assign lt_signed   = sum[31] ^ ovf;         // sign corrected for overflow.
    assign lt_unsigned = ~carry_out;            // borrow out of a - b.

    always_comb begin
        case (op_i[2:1])
            2'b01:   shift_res = opr_a_i << shamt_i;
            2'b10:   shift_res = opr_a_i >> shamt_i;
            2'b11:   shift_res = $unsigned($signed(opr_a_i) >>> shamt_i);
            default: shift_res = opr_a_i;
        endcase
    end

    always_comb begin
        case (op_i[5:3])
            3'b001:  logic_res = opr_a_i & opr_b_i;
            3'b010:  logic_res = opr_a_i | opr_b_i;
            3'b011:  logic_res = opr_a_i ^ opr_b_i;
            3'b100:  logic_res = ~(opr_a_i | opr_b_i);
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            ALU_ADD, ALU_SUB:           value = sum;
            ALU_SLL, ALU_SRL, ALU_SRA:  value = shift_res;
            ALU_AND, ALU_OR,
            ALU_XOR, ALU_NOR:           value = logic_res;
            ALU_SLT:                    value = {31'd0, lt_signed};
            ALU_SLTU:                   value = {31'd0, lt_unsigned};
            default:                    value = '0;
        endcase
    end

    assign res_o.value = value;
    assign res_o.zero  = (value == '0);
    assign res_o.neg   = value[31];

endmodule

`default_nettype wire

// ==== verilog/mips_alu_pkg.sv ====
// ALU operation codes, execute control struct, ALU result struct
`default_nettype none

package mips_alu_pkg;

    import mips_isa_pkg::*;

    // op fields are [5:3] logic function, [2:1] shift kind, [0] invert B with carry-in
    localparam logic [5:0] ALU_ADD  = 6'b000_00_0;
    localparam logic [5:0] ALU_SUB  = 6'b000_00_1;
    localparam logic [5:0] ALU_SLL  = 6'b000_01_0;
    localparam logic [5:0] ALU_SRL  = 6'b000_10_0;
    localparam logic [5:0] ALU_SRA  = 6'b000_11_0;
    localparam logic [5:0] ALU_AND  = 6'b001_00_0;
    localparam logic [5:0] ALU_OR   = 6'b010_00_0;
    localparam logic [5:0] ALU_XOR  = 6'b011_00_0;
    localparam logic [5:0] ALU_NOR  = 6'b100_00_0;
    localparam logic [5:0] ALU_SLT  = 6'b101_00_1;   // compares subtract.
    localparam logic [5:0] ALU_SLTU = 6'b110_00_1;

    typedef struct packed {
        logic [5:0]  alu_op;
        logic        use_imm;               // operand b from imm.
        logic        use_shamt;             // shift amount from imm[4:0].
        logic [31:0] imm;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic        wr_en;
    } exec_ctrl_t;

    typedef struct packed {
        logic [31:0] value;
        logic        zero;                  // value is zero.
        logic        neg;                   // value bit 31.
    } alu_res_t;

endpackage

`default_nettype wire

// ==== verilog/mips_decoder.sv ====
// instruction decoder mapping a word to execute control and flagging illegal encodings
`timescale 1ns/100ps
`default_nettype none

module mips_decoder
    import mips_isa_pkg::*;
    import mips_alu_pkg::*;
(
    input  wire instr_t     instr_i,
    output exec_ctrl_t      ctrl_o,
    output logic            illegal_o
);

    logic [31:0] imm_sext;
    logic [31:0] imm_zext;

    assign imm_sext = {{16{instr_i.i.imm[15]}}, instr_i.i.imm};
    assign imm_zext = {16'h0000, instr_i.i.imm};

    always_comb begin
        // I-type layout as the default with R-type overrides below
        ctrl_o           = '0;
        ctrl_o.alu_op    = ALU_ADD;
        ctrl_o.use_imm   = 1'b1;
        ctrl_o.imm       = imm_sext;
        ctrl_o.rs        = instr_i.i.rs;
        ctrl_o.rt        = instr_i.i.rt;
        ctrl_o.rd        = instr_i.i.rt;
        ctrl_o.wr_en     = 1'b1;
        illegal_o        = 1'b0;

        case (instr_i.r.opcode)
            OP_RTYPE: begin
                ctrl_o.use_imm = 1'b0;
                ctrl_o.rd      = instr_i.r.rd;
                ctrl_o.imm     = {27'd0, instr_i.r.shamt};
                case (instr_i.r.funct)
                    FN_ADD:  ctrl_o.alu_op = ALU_ADD;
                    FN_SUB:  ctrl_o.alu_op = ALU_SUB;
                    FN_AND:  ctrl_o.alu_op = ALU_AND;
                    FN_OR:   ctrl_o.alu_op = ALU_OR;
                    FN_XOR:  ctrl_o.alu_op = ALU_XOR;
                    FN_NOR:  ctrl_o.alu_op = ALU_NOR;
                    FN_SLT:  ctrl_o.alu_op = ALU_SLT;
                    FN_SLTU: ctrl_o.alu_op = ALU_SLTU;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        ctrl_o.use_shamt = 1'b1;
                        ctrl_o.rs        = instr_i.r.rt;    // shift source is rt.
                        ctrl_o.alu_op    = (instr_i.r.funct == FN_SLL) ? ALU_SLL :
                                           (instr_i.r.funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                    end
                    default: illegal_o = 1'b1;
                endcase
            end
            OP_ADDI:  ctrl_o.alu_op = ALU_ADD;
            OP_SLTI:  ctrl_o.alu_op = ALU_SLT;
            OP_SLTIU: ctrl_o.alu_op = ALU_SLTU;   // sign-extended then compared unsigned.
            OP_ANDI: begin
                ctrl_o.alu_op = ALU_AND;
                ctrl_o.imm    = imm_zext;
            end
            OP_ORI: begin
                ctrl_o.alu_op = ALU_OR;
                ctrl_o.imm    = imm_zext;
            end
            OP_XORI: begin
                ctrl_o.alu_op = ALU_XOR;
                ctrl_o.imm    = imm_zext;
            end
            OP_LUI: begin
                ctrl_o.rs  = '0;                    // r0 + upper imm.
                ctrl_o.imm = {instr_i.i.imm, 16'h0000};
            end
            default: illegal_o = 1'b1;
        endcase

        // r0 + 0 gives a zero result and no write
        if (illegal_o) begin
            ctrl_o         = '0;
            ctrl_o.alu_op  = ALU_ADD;
            ctrl_o.use_imm = 1'b1;
        end
    end

    always_comb begin
        assert final (ctrl_o.alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
                                            ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
                                            ALU_SLT, ALU_SLTU})
        else $error("decoder drives undefined alu_op %b", ctrl_o.alu_op);
    end

endmodule

`default_nettype wire

// ==== verilog/mips_exec_unit.sv ====
// execute core top with decoder, register file, ALU, operand select and result register
`timescale 1ns/100ps
`default_nettype none

module mips_exec_unit
    import mips_isa_pkg::*;
    import mips_alu_pkg::*;
(
    input  wire             clk_i,
    input  wire             rst_n_i,
    input  wire             instr_valid_i,
    input  wire instr_t     instr_i,
    output logic            result_valid_o,
    output alu_res_t        result_o,
    output reg_addr_t       dest_o,
    output logic            illegal_o
);

    exec_ctrl_t  ctrl;
    logic        illegal;
    logic [31:0] rd_data_a;
    logic [31:0] rd_data_b;
    logic [31:0] opr_b;
    logic [4:0]  shamt;
    alu_res_t    alu_res;
    logic        rf_wr_en;

    mips_decoder u_decoder (
        .instr_i   (instr_i),
        .ctrl_o    (ctrl),
        .illegal_o (illegal)
    );

    assign rf_wr_en = instr_valid_i && ctrl.wr_en && !illegal && (ctrl.rd != '0);

    mips_regfile u_regfile (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rd_addr_a_i (ctrl.rs),
        .rd_addr_b_i (ctrl.rt),
        .rd_data_a_o (rd_data_a),
        .rd_data_b_o (rd_data_b),
        .wr_en_i     (rf_wr_en),
        .wr_addr_i   (ctrl.rd),
        .wr_data_i   (alu_res.value)
    );

    assign opr_b = ctrl.use_imm ? ctrl.imm : rd_data_b;
    assign shamt = ctrl.use_shamt ? ctrl.imm[4:0] : opr_b[4:0];

    mips_alu u_alu (
        .opr_a_i (rd_data_a),
        .opr_b_i (opr_b),
        .shamt_i (shamt),
        .op_i    (ctrl.alu_op),
        .res_o   (alu_res)
    );

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_valid_o <= 1'b0;
            result_o       <= '0;
            dest_o         <= '0;
            illegal_o      <= 1'b0;
        end else begin
            result_valid_o <= instr_valid_i;
            if (instr_valid_i) begin          // hold last result between issues.
                result_o  <= alu_res;
                dest_o    <= ctrl.rd;
                illegal_o <= illegal;
            end
        end
    end

    a_result_latency : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_valid_i |=> result_valid_o)
    else $error("no result one cycle after issue");

    a_no_spurious_result : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !instr_valid_i |=> !result_valid_o)
    else $error("result valid without a prior issue");

endmodule

`default_nettype wire

// ==== verilog/mips_isa_pkg.sv ====
// instruction formats, opcode and funct codes, instruction union
`default_nettype none

package mips_isa_pkg;

    localparam int REG_COUNT = 32;

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_SLTI  = 6'b001010;
    localparam logic [5:0] OP_SLTIU = 6'b001011;
    localparam logic [5:0] OP_ANDI  = 6'b001100;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_XORI  = 6'b001110;
    localparam logic [5:0] OP_LUI   = 6'b001111;

    // funct codes for OP_RTYPE only
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    typedef logic [4:0] reg_addr_t;

    typedef struct packed {
        logic [5:0] opcode;                 // bits 31..26.
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;                  // bits 5..0.
    } instr_r_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;                    // destination for I-type.
        logic [15:0] imm;
    } instr_i_t;

    // one 32-bit word in two field layouts
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

endpackage

`default_nettype wire

// ==== verilog/mips_regfile.sv ====
// 32 x 32-bit register file, two read ports, one write port, r0 hardwired
`timescale 1ns/100ps
`default_nettype none

module mips_regfile
    import mips_isa_pkg::*;
(
    input  wire             clk_i,
    input  wire             rst_n_i,
    input  wire reg_addr_t  rd_addr_a_i,
    input  wire reg_addr_t  rd_addr_b_i,
    output logic [31:0]     rd_data_a_o,
    output logic [31:0]     rd_data_b_o,
    input  wire             wr_en_i,
    input  wire reg_addr_t  wr_addr_i,
    input  wire [31:0]      wr_data_i
);

    logic [31:0] regs [1:REG_COUNT-1];     // r0 not stored.

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs[rd_addr_a_i];
    assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs[rd_addr_b_i];

    // r0 reads zero on both ports even after writes elsewhere
    a_r0_reads_zero : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ((rd_addr_a_i == '0) |-> (rd_data_a_o == '0)) and
        ((rd_addr_b_i == '0) |-> (rd_data_b_o == '0)))
    else $error("register zero read back nonzero");

    // the top filters writes to r0
    a_no_r0_write : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_en_i |-> (wr_addr_i != '0))
    else $error("write enable asserted for register zero");

endmodule

`default_nettype wire
